//--- mem_unit.f
hw/mem_pkg.sv
hw/ctrl_pkg.sv
hw/mem_seq_if.sv
hw/req_buffer.sv
hw/byte_counter.sv
hw/word_shifter.sv
hw/access_fsm.sv
hw/mem_unit.sv
tb/sim_ram.sv
tb/tb_mem_unit.sv

//--- Makefile
# Verilator build and run of the memory unit testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_unit
FILELIST  ?= mem_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run passes only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_mem_unit.sv
// memory unit testbench
// random fetches, loads and stores under bus pauses, checked against a byte model
`timescale 1ns/100ps
`default_nettype none

module tb_mem_unit import mem_pkg::*; ();

    localparam int    CLK_PERIOD = 100;
    localparam int    RAM_BYTES  = 131072;
    localparam int    ROUNDS     = 40;
    localparam int    N_REQ      = ROUNDS * 6 + 2;
    localparam addr_t IO_ADDR    = 32'h0003_0000;

    typedef logic [16:0] ram_idx_t;

    logic        clk_in = 1'b0;
    logic        rst_n;
    logic        rdy_in = 1'b1;
    logic        io_buffer_full;
    logic [7:0]  mem_din;
    logic [7:0]  mem_dout;
    addr_t       mem_a;
    logic        mem_wr;
    logic        inst_en;
    addr_t       inst_addr;
    logic        inst_done;
    word_t       inst_data;
    logic        data_en;
    logic        data_store;
    addr_t       data_addr;
    word_t       data_wdata;
    len_t        data_len;
    logic        data_done;
    word_t       data_rdata;
    logic [31:0] io_count;
    logic [7:0]  io_last;

    logic [7:0]  model [RAM_BYTES];
    logic [31:0] rng;
    logic [31:0] rdy_rng;
    logic        pause_on;
    logic        mon_on;
    logic        was_paused = 1'b0;
    addr_t       paused_a = '0;
    logic        paused_full = 1'b0;

    mem_unit u_dut (.*);
    sim_ram  u_ram (.*);

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic int len_bytes(input len_t len);
        case (len)
            LEN_BYTE: return 1;
            LEN_HALF: return 2;
            default:  return 4;
        endcase
    endfunction

    // little-endian bytes from the model, upper bytes left zero
    function automatic word_t model_word(input addr_t addr, input int n);
        word_t w;
        w = '0;
        for (int k = 0; k < n; k++) begin
            w = w | (word_t'(model[ram_idx_t'(addr + addr_t'(k))]) << (8 * k));
        end
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic report_mismatch(input string what, input word_t got, input word_t exp);
        abort_run($sformatf("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge clk_in);
        #1;
    endtask

    // strobes stay up until an edge with rdy_in high takes them
    task automatic strobe(input logic use_inst, input logic use_data);
        logic taken;
        taken   = 1'b0;
        inst_en = use_inst;
        data_en = use_data;
        while (!taken) begin
            @(posedge clk_in);
            taken = rdy_in;
            #1;
        end
        inst_en = 1'b0;
        data_en = 1'b0;
    endtask

    task automatic wait_data_done();
        do begin
            @(negedge clk_in);
        end while (!(data_done && rdy_in));
    endtask

    task automatic store_and_mirror(input addr_t addr, input word_t wdata, input len_t len);
        data_store = 1'b1;
        data_addr  = addr;
        data_wdata = wdata;
        data_len   = len;
        strobe(1'b0, 1'b1);
        wait_data_done();
        for (int k = 0; k < len_bytes(len); k++) begin
            model[ram_idx_t'(addr + addr_t'(k))] = 8'(wdata >> (8 * k));
        end
        next_cycle();
    endtask

    task automatic load_and_compare(input addr_t addr, input len_t len);
        word_t exp;
        exp        = model_word(addr, len_bytes(len));
        data_store = 1'b0;
        data_addr  = addr;
        data_len   = len;
        strobe(1'b0, 1'b1);
        wait_data_done();
        assert (data_rdata == exp) else report_mismatch("load data", data_rdata, exp);
        next_cycle();
    endtask

    task automatic fetch_and_compare(input addr_t addr);
        word_t exp;
        exp       = model_word(addr, 4);
        inst_addr = addr;
        strobe(1'b1, 1'b0);
        do begin
            @(negedge clk_in);
        end while (!(inst_done && rdy_in));
        assert (inst_data == exp) else report_mismatch("fetch data", inst_data, exp);
        next_cycle();
    endtask

    // fetch and load strobed together, the load has to finish first
    task automatic fetch_beside_load(input addr_t iaddr, input addr_t daddr, input len_t len);
        word_t iexp;
        word_t dexp;
        logic  data_seen;
        logic  inst_seen;
        iexp       = model_word(iaddr, 4);
        dexp       = model_word(daddr, len_bytes(len));
        data_seen  = 1'b0;
        inst_seen  = 1'b0;
        inst_addr  = iaddr;
        data_store = 1'b0;
        data_addr  = daddr;
        data_len   = len;
        strobe(1'b1, 1'b1);
        while (!inst_seen) begin
            @(negedge clk_in);
            if (rdy_in && data_done) begin
                assert (data_rdata == dexp) else report_mismatch("paired load", data_rdata, dexp);
                data_seen = 1'b1;
            end
            if (rdy_in && inst_done) begin
                assert (data_seen) else abort_run("fetch finished before the paired load");
                assert (inst_data == iexp) else report_mismatch("paired fetch", inst_data, iexp);
                inst_seen = 1'b1;
            end
        end
        next_cycle();
    endtask

    task automatic io_store_under_stall(input addr_t addr, input logic [7:0] b);
        logic [31:0] count0;
        count0         = io_count;
        io_buffer_full = 1'b1;
        data_store     = 1'b1;
        data_addr      = addr;
        data_wdata     = {24'h0, b};
        data_len       = LEN_BYTE;
        strobe(1'b0, 1'b1);
        repeat (20) @(posedge clk_in);
        #1;
        assert (io_count == count0) else abort_run("I/O byte written while the buffer was full");
        io_buffer_full = 1'b0;
        wait_data_done();
        assert (io_count == count0 + 32'd1) else abort_run("I/O store did not write exactly once");
        assert (io_last == b) else report_mismatch("I/O byte", word_t'(io_last), word_t'(b));
        next_cycle();
    endtask

    // random pauses, on their own stream so the request sequence stays fixed
    always @(posedge clk_in) begin
        #1;
        if (pause_on) begin
            rdy_rng = xorshift(rdy_rng);
            rdy_in  = (rdy_rng[1:0] != 2'b00);
        end else begin
            rdy_in = 1'b1;
        end
    end

    // bus rules that hold in every cycle
    always @(negedge clk_in) begin
        if (mon_on) begin
            assert (rdy_in || !mem_wr) else abort_run("mem_wr high while rdy_in is low");
            assert (!(io_buffer_full && mem_wr && mem_a[17:16] == IO_SEL))
                else abort_run("I/O write while io_buffer_full is high");
            // a stall release alone moves mem_a
            if (was_paused && io_buffer_full == paused_full) begin
                assert (mem_a == paused_a)
                    else report_mismatch("mem_a over a pause", mem_a, paused_a);
            end
            was_paused  = !rdy_in;
            paused_a    = mem_a;
            paused_full = io_buffer_full;
        end
    end

    initial begin
        #(N_REQ * 40 * CLK_PERIOD);
        abort_run("timeout, the requests did not all complete");
    end

    initial begin
        addr_t a;
        len_t  len;
        rng            = 32'he030df17;
        rdy_rng        = xorshift(32'he030df17);
        pause_on       = 1'b0;
        mon_on         = 1'b0;
        rst_n          = 1'b0;
        io_buffer_full = 1'b0;
        inst_en        = 1'b0;
        inst_addr      = '0;
        data_en        = 1'b0;
        data_store     = 1'b0;
        data_addr      = '0;
        data_wdata     = '0;
        data_len       = LEN_BYTE;
        repeat (5) @(posedge clk_in);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < RAM_BYTES; i++) begin
            model[ram_idx_t'(i)] = u_ram.mem[ram_idx_t'(i)];
        end
        mon_on = 1'b1;

        // quiet bus with no request
        repeat (4) begin
            @(negedge clk_in);
            assert (!mem_wr && !inst_done && !data_done && mem_a == '0)
                else abort_run("bus activity after reset with no request");
        end
        next_cycle();

        pause_on = 1'b1;
        for (int r = 0; r < ROUNDS; r++) begin
            a   = rand32() % (RAM_BYTES - 8);
            len = len_t'(rand32() % 3);
            store_and_mirror(a, rand32(), len);
            load_and_compare(a, len);
            load_and_compare(a + (rand32() % 4), len_t'(rand32() % 3));
            fetch_and_compare(rand32() % (RAM_BYTES - 8));
            fetch_beside_load(rand32() % (RAM_BYTES - 8), a + (rand32() % 4),
                              len_t'(rand32() % 3));
        end
        io_store_under_stall(IO_ADDR | (rand32() & 32'hff), 8'(rand32()));
        io_store_under_stall(IO_ADDR | (rand32() & 32'hff), 8'(rand32()));

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/sim_ram.sv
// behavioural byte RAM for the memory bus
// 128 KB, one-cycle read latency, I/O region writes go to a small log
`timescale 1ns/100ps
`default_nettype none

module sim_ram import mem_pkg::*; (
    input  wire logic        clk_in,
    input  wire logic        rdy_in,
    input  addr_t            mem_a,
    input  wire logic [7:0]  mem_dout,
    input  wire logic        mem_wr,
    output logic      [7:0]  mem_din,
    output logic      [31:0] io_count,
    output logic      [7:0]  io_last
);

    localparam int RAM_BYTES = 131072;

    logic [7:0] mem [RAM_BYTES];

    // fill mixes every address bit so a wrong address shows up
    initial begin
        for (int i = 0; i < RAM_BYTES; i++) begin
            mem[17'(i)] <= 8'(i ^ (i >> 3) ^ (i >> 8) ^ (i >> 16));
        end
        mem_din  <= '0;
        io_count <= '0;
        io_last  <= '0;
    end

    always @(posedge clk_in) begin
        // read data frozen along with the bus during a pause
        if (rdy_in) begin
            mem_din <= mem[mem_a[16:0]];
        end
        if (mem_wr) begin
            if (mem_a[17:16] == IO_SEL) begin
                io_count <= io_count + 32'd1;
                io_last  <= mem_dout;
            end else begin
                mem[mem_a[16:0]] <= mem_dout;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_unit.sv
// memory unit top
// serves fetch and load/store ports over the byte-wide memory bus
`timescale 1ns/100ps
`default_nettype none

module mem_unit import mem_pkg::*; (
    input  wire logic        clk_in,
    input  wire logic        rst_n,
    input  wire logic        rdy_in,
    input  wire logic [7:0]  mem_din,
    input  wire logic        io_buffer_full,
    output logic      [7:0]  mem_dout,
    output addr_t            mem_a,
    output logic             mem_wr,
    input  wire logic        inst_en,
    input  addr_t            inst_addr,
    output logic             inst_done,
    output word_t            inst_data,
    input  wire logic        data_en,
    input  wire logic        data_store,
    input  addr_t            data_addr,
    input  word_t            data_wdata,
    input  len_t             data_len,
    output logic             data_done,
    output word_t            data_rdata
);

    inst_req_t inst_req;
    inst_req_t inst_held;
    data_req_t data_req;
    data_req_t data_held;
    logic      inst_pending;
    logic      data_pending;
    logic      inst_grant;
    logic      data_grant;
    logic      capture;
    logic      clear;
    word_t     rword;

    mem_seq_if seq_bus ();

    assign inst_req = '{addr: inst_addr};
    assign data_req = '{store: data_store, addr: data_addr, wdata: data_wdata, len: data_len};

    req_buffer #(.payload_t(inst_req_t)) u_inst_buf (
        .clk_in  (clk_in),
        .rst_n   (rst_n),
        .rdy_in  (rdy_in),
        .en      (inst_en),
        .req     (inst_req),
        .grant   (inst_grant),
        .pending (inst_pending),
        .held    (inst_held)
    );

    req_buffer #(.payload_t(data_req_t)) u_data_buf (
        .clk_in  (clk_in),
        .rst_n   (rst_n),
        .rdy_in  (rdy_in),
        .en      (data_en),
        .req     (data_req),
        .grant   (data_grant),
        .pending (data_pending),
        .held    (data_held)
    );

    access_fsm u_fsm (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .rdy_in         (rdy_in),
        .io_buffer_full (io_buffer_full),
        .inst_pending   (inst_pending),
        .inst_held      (inst_held),
        .data_pending   (data_pending),
        .data_held      (data_held),
        .seq            (seq_bus.seq),
        .inst_grant     (inst_grant),
        .data_grant     (data_grant),
        .capture        (capture),
        .clear          (clear),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .inst_done      (inst_done),
        .data_done      (data_done)
    );

    byte_counter u_cnt (
        .clk_in (clk_in),
        .rst_n  (rst_n),
        .rdy_in (rdy_in),
        .seq    (seq_bus.cnt)
    );

    word_shifter u_shift (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rdy_in   (rdy_in),
        .wdata    (data_held.wdata),
        .byte_idx (seq_bus.byte_idx),
        .capture  (capture),
        .clear    (clear),
        .mem_din  (mem_din),
        .wbyte    (mem_dout),
        .rword    (rword)
    );

    // one assembled word serves whichever port is signalled done
    assign inst_data  = rword;
    assign data_rdata = rword;

endmodule

`default_nettype wire

//--- hw/access_fsm.sv
// memory access sequencer
// arbitrates fetch and load/store, issues byte bus cycles and signals completion
`timescale 1ns/100ps
`default_nettype none

module access_fsm import mem_pkg::*, ctrl_pkg::*; (
    input  wire logic clk_in,
    input  wire logic rst_n,
    input  wire logic rdy_in,
    input  wire logic io_buffer_full,
    input  wire logic inst_pending,
    input  inst_req_t inst_held,
    input  wire logic data_pending,
    input  data_req_t data_held,
    mem_seq_if.seq    seq,
    output logic      inst_grant,
    output logic      data_grant,
    output logic      capture,
    output logic      clear,
    output addr_t     mem_a,
    output logic      mem_wr,
    output logic      inst_done,
    output logic      data_done
);

    typedef logic [BYTE_IDX_W:0] count_t;

    seq_state_t state;
    logic       serve_data;
    logic       io_stall;
    logic       bus_active;
    addr_t      base;
    count_t     len_bytes;

    // loads and stores win over fetches
    assign data_grant = (state == IDLE) && data_pending;
    assign inst_grant = (state == IDLE) && inst_pending && !data_pending;

    always_comb begin
        case (data_held.len)
            LEN_BYTE: len_bytes = count_t'(1);
            LEN_HALF: len_bytes = count_t'(2);
            default:  len_bytes = count_t'(4);
        endcase
    end

    assign seq.start  = data_grant || inst_grant;
    assign seq.nbytes = data_grant ? len_bytes : count_t'(4);
    assign clear      = seq.start;

    // uart side full, hold the I/O store off the bus
    assign io_stall = (state == DATA_WR) && (data_held.addr[17:16] == IO_SEL) &&
                      io_buffer_full;

    assign bus_active = (state == INST) || (state == DATA_RD) ||
                        ((state == DATA_WR) && !io_stall);
    assign seq.advance = bus_active;

    assign base  = (state == INST) ? inst_held.addr : data_held.addr;
    // address parked at zero between bus bytes, so no stray I/O read
    assign mem_a  = bus_active ? base + addr_t'(seq.byte_idx) : '0;
    assign mem_wr = (state == DATA_WR) && !io_stall && rdy_in;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state      <= IDLE;
            serve_data <= 1'b0;
            capture    <= 1'b0;
            inst_done  <= 1'b0;
            data_done  <= 1'b0;
        end else if (rdy_in) begin
            // read data returns one cycle after its address
            capture   <= (state == INST) || (state == DATA_RD);
            inst_done <= (state == FINISH) && !serve_data;
            data_done <= (state == FINISH) && serve_data;
            case (state)
                IDLE: begin
                    if (data_pending) begin
                        serve_data <= 1'b1;
                        state      <= data_held.store ? DATA_WR : DATA_RD;
                    end else if (inst_pending) begin
                        serve_data <= 1'b0;
                        state      <= INST;
                    end
                end
                INST, DATA_RD, DATA_WR: begin
                    if (bus_active && seq.last) begin
                        state <= FINISH;
                    end
                end
                // last read byte lands in the word here
                FINISH: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/word_shifter.sv
// byte lane shifter
// picks store bytes out of the write word and packs read bytes into a word
`timescale 1ns/100ps
`default_nettype none

module word_shifter import mem_pkg::*, ctrl_pkg::*; (
    input  wire logic                  clk_in,
    input  wire logic                  rst_n,
    input  wire logic                  rdy_in,
    input  word_t                      wdata,
    input  wire logic [BYTE_IDX_W-1:0] byte_idx,
    input  wire logic                  capture,
    input  wire logic                  clear,
    input  wire logic [7:0]            mem_din,
    output logic [7:0]                 wbyte,
    output word_t                      rword
);

    // lane of the byte now on mem_din, one cycle behind its address
    logic [BYTE_IDX_W-1:0] lane_q;

    // store byte for the address on the bus this cycle
    assign wbyte = wdata[byte_idx*8 +: 8];

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            lane_q <= '0;
        end else if (rdy_in) begin
            lane_q <= byte_idx;
        end
    end

    // short loads keep zeros in the upper lanes
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (clear) begin
                rword <= '0;
            end else if (capture) begin
                rword[lane_q*8 +: 8] <= mem_din;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/byte_counter.sv
// byte position counter
// walks the byte index of one access and flags its final byte
`timescale 1ns/100ps
`default_nettype none

module byte_counter import ctrl_pkg::*; (
    input  wire logic clk_in,
    input  wire logic rst_n,
    input  wire logic rdy_in,
    mem_seq_if.cnt    seq
);

    logic [BYTE_IDX_W-1:0] idx_q;
    logic [BYTE_IDX_W:0]   nbytes_q;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            idx_q    <= '0;
            nbytes_q <= '0;
        end else if (rdy_in) begin
            if (seq.start) begin
                idx_q    <= '0;
                nbytes_q <= seq.nbytes;
            end else if (seq.advance) begin
                // wraps to zero after a full word
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    assign seq.byte_idx = idx_q;
    assign seq.last     = (idx_q == BYTE_IDX_W'(nbytes_q - 1'b1));

    // sequencer must leave the bus phase after the final byte
    a_no_overrun: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        (rdy_in && seq.advance && seq.last) |=> !seq.advance
    );

endmodule

`default_nettype wire

//--- hw/req_buffer.sv
// single entry request holder
// latches a port request on its strobe and keeps it pending until granted
`timescale 1ns/100ps
`default_nettype none

module req_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic clk_in,
    input  wire logic rst_n,
    input  wire logic rdy_in,
    input  wire logic en,
    input  payload_t  req,
    input  wire logic grant,
    output logic      pending,
    output payload_t  held
);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (rdy_in) begin
            if (en) begin
                pending <= 1'b1;
            end else if (grant) begin
                pending <= 1'b0;
            end
        end
    end

    // request fields stay put after the grant for the sequencer to use
    always_ff @(posedge clk_in) begin
        if (rdy_in && en) begin
            held <= req;
        end
    end

    // the requester waits for its done, so it never overruns this entry
    a_no_overrun: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        (rdy_in && en) |-> !pending
    );

endmodule

`default_nettype wire

//--- hw/mem_seq_if.sv
// sequencer to byte counter link
// access start, byte count and per-byte advance, with index and last flag back
`timescale 1ns/100ps
`default_nettype none

interface mem_seq_if import ctrl_pkg::*; ();

    logic                  start;
    logic [BYTE_IDX_W:0]   nbytes;
    logic                  advance;
    logic [BYTE_IDX_W-1:0] byte_idx;
    logic                  last;

    // sequencer side
    modport seq (
        output start, nbytes, advance,
        input  byte_idx, last
    );

    // counter side
    modport cnt (
        input  start, nbytes, advance,
        output byte_idx, last
    );

endinterface

`default_nettype wire

//--- hw/ctrl_pkg.sv
// access sequencer definitions
// FSM state encoding and the byte index width
`default_nettype none

package ctrl_pkg;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        INST,
        DATA_RD,
        DATA_WR,
        FINISH
    } seq_state_t;

    // byte position within one access, up to 4 bytes
    localparam int BYTE_IDX_W = 2;

endpackage

`default_nettype wire

//--- hw/mem_pkg.sv
// memory side definitions
// address map, access length codes and the request payloads of both ports
`default_nettype none

package mem_pkg;

    // byte address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // access length code
    typedef logic [1:0] len_t;

    localparam len_t LEN_BYTE = 2'd0;
    localparam len_t LEN_HALF = 2'd1;
    localparam len_t LEN_WORD = 2'd2;

    // address bits 17:16 both set select the I/O region
    localparam logic [1:0] IO_SEL = 2'b11;

    // fetch request, always a full word
    typedef struct packed {
        addr_t addr;
    } inst_req_t;

    // load or store request
    typedef struct packed {
        logic  store;
        addr_t addr;
        word_t wdata;
        len_t  len;
    } data_req_t;

endpackage

`default_nettype wire
